// ==== build.f ====
src/cadr_mem_pkg.sv
src/map_if.sv
src/cycle_seq.sv
src/vma_md_ctl.sv
src/vma_md_regs.sv
src/vmem_map.sv
src/mem_ctl_top.sv
verification/mem_ctl_tb.sv

// ==== src/cadr_mem_pkg.sv ====
// Widths, map field positions, micro-operation codes and sequencer states
package cadr_mem_pkg;

   ////////////////////
   // Widths
   ////////////////////

   typedef logic [31:0] vaddr_t;
   typedef logic [31:0] word_t;
   typedef logic [21:0] paddr_t;
   typedef logic [4:0]  l1_entry_t;
   typedef logic [23:0] l2_entry_t;

   // Level-1 index is VMA 23:13, level-2 index is l1 entry then VMA 12:8
   localparam int L1_INDEX_LO  = 13;
   localparam int L1_INDEX_W   = 11;
   localparam int L2_OFFSET_LO = 8;
   localparam int L2_INDEX_W   = $bits(l1_entry_t) + (L1_INDEX_LO - L2_OFFSET_LO);

   typedef logic [L1_INDEX_W-1:0] l1_index_t;
   typedef logic [L2_INDEX_W-1:0] l2_index_t;

   // Level-2 entry fields
   localparam int L2_RD_BIT = 23;
   localparam int L2_WR_BIT = 22;
   localparam int PAGE_W    = 14;

   // VMA bits that pick the map level on a map write
   localparam int MAPWR_L1_BIT = 26;
   localparam int MAPWR_L2_BIT = 25;

   ////////////////////
   // Codes
   ////////////////////

   // Same encoding as ir[20:19]
   typedef enum logic [1:0] {
      MEMOP_NONE  = 2'b00,
      MEMOP_READ  = 2'b01,
      MEMOP_WRITE = 2'b10,
      MEMOP_MAPWR = 2'b11
   } memop_t;

   typedef enum logic [1:0] {
      DEST_NONE = 2'b00,
      DEST_VMA  = 2'b01,
      DEST_MDR  = 2'b10
   } dest_t;

   typedef enum logic [1:0] {
      SRC_NONE = 2'b00,
      SRC_MAP  = 2'b01,
      SRC_MD   = 2'b10
   } src_t;

   typedef enum logic [2:0] {
      ST_IDLE    = 3'd0,
      ST_DECODE  = 3'd1,
      ST_READ    = 3'd2,
      ST_WRITE   = 3'd3,
      ST_MMU     = 3'd4,
      ST_WAIT_RD = 3'd5
   } cyc_state_t;

endpackage

// ==== src/cycle_seq.sv ====
// Machine cycle FSM with memory request, read response wait and timeout
module cycle_seq #(
   parameter int MEM_TIMEOUT_CYCLES = 64
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     uop_valid,
   output logic                     uop_ready,
   input  logic                     mem_start,
   input  logic                     mem_we_req,
   input  logic                     access_ok,
   output logic                     mem_valid,
   input  logic                     mem_ready,
   input  logic                     mem_rvalid,
   output cadr_mem_pkg::cyc_state_t state,
   output logic                     load_md_mem,
   output logic                     res_valid,
   output logic                     res_fault
);
   import cadr_mem_pkg::*;

   localparam int CNT_W = $clog2(MEM_TIMEOUT_CYCLES + 1);

   cyc_state_t       next_state;
   logic [CNT_W-1:0] wait_cnt;
   logic             waiting;
   logic             timeout;
   logic             done;
   logic             fault;

   assign uop_ready = (state == ST_IDLE);

   // Request goes out only for an allowed access
   assign mem_valid   = (state == ST_MMU) && mem_start && access_ok;
   assign load_md_mem = (state == ST_WAIT_RD) && mem_rvalid;

   assign waiting = (mem_valid && !mem_ready) || ((state == ST_WAIT_RD) && !mem_rvalid);
   assign timeout = (wait_cnt == CNT_W'(MEM_TIMEOUT_CYCLES));

   ////////////////////
   // Next state
   ////////////////////

   always_comb begin
      next_state = state;
      done       = 1'b0;
      fault      = 1'b0;
      case (state)
         ST_IDLE: begin
            if (uop_valid) begin
               next_state = ST_DECODE;
            end
         end
         ST_DECODE: next_state = ST_READ;
         ST_READ:   next_state = ST_WRITE;
         ST_WRITE:  next_state = ST_MMU;
         ST_MMU: begin
            if (!mem_start) begin
               done = 1'b1;
            end else if (!access_ok) begin
               done  = 1'b1;
               fault = 1'b1;
            end else if (mem_ready) begin
               if (mem_we_req) begin
                  done = 1'b1;
               end else begin
                  next_state = ST_WAIT_RD;
               end
            end else if (timeout) begin
               done  = 1'b1;
               fault = 1'b1;
            end
         end
         ST_WAIT_RD: begin
            if (mem_rvalid) begin
               done = 1'b1;
            end else if (timeout) begin
               done  = 1'b1;
               fault = 1'b1;
            end
         end
         default: next_state = ST_IDLE;
      endcase
      if (done) begin
         next_state = ST_IDLE;
      end
   end

   ////////////////////
   // State and result
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= ST_IDLE;
         wait_cnt  <= '0;
         res_valid <= 1'b0;
         res_fault <= 1'b0;
      end else begin
         state     <= next_state;
         res_valid <= done;
         res_fault <= fault;
         // Each wait is bounded on its own
         if (waiting && !timeout) begin
            wait_cnt <= wait_cnt + 1'b1;
         end else begin
            wait_cnt <= '0;
         end
      end
   end

endmodule

// ==== src/map_if.sv ====
// Map strobe, write data and read-back bundle between control and map
interface map_if;
   import cadr_mem_pkg::*;

   // Read and write strobes per level
   logic vm0rp;
   logic vm0wp;
   logic vm1rp;
   logic vm1wp;

   // Write data comes from MD
   word_t wdata;

   // Registered read results
   l1_entry_t l1_q;
   l2_entry_t l2_q;

   modport ctl (
      output vm0rp, vm0wp, vm1rp, vm1wp
   );

   modport map (
      input  vm0rp, vm0wp, vm1rp, vm1wp, wdata,
      output l1_q, l2_q
   );

endinterface

// ==== src/mem_ctl_top.sv ====
// Virtual memory control top with micro-operation capture and result select
module mem_ctl_top #(
   parameter int MEM_TIMEOUT_CYCLES = 64
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 uop_valid,
   output logic                 uop_ready,
   input  cadr_mem_pkg::dest_t  uop_dest,
   input  cadr_mem_pkg::src_t   uop_src,
   input  cadr_mem_pkg::memop_t uop_memop,
   input  cadr_mem_pkg::word_t  uop_data,
   output logic                 res_valid,
   output cadr_mem_pkg::word_t  res_data,
   output logic                 res_fault,
   output logic                 mem_valid,
   input  logic                 mem_ready,
   output logic                 mem_we,
   output cadr_mem_pkg::paddr_t mem_addr,
   output cadr_mem_pkg::word_t  mem_wdata,
   input  logic                 mem_rvalid,
   input  cadr_mem_pkg::word_t  mem_rdata
);
   import cadr_mem_pkg::*;

   dest_t      dest_q;
   src_t       src_q;
   memop_t     memop_q;
   word_t      data_q;
   cyc_state_t state;
   vaddr_t     vma;
   word_t      md;
   paddr_t     phys;
   logic       vma_load;
   logic       md_load;
   logic       mem_start;
   logic       mem_we_req;
   logic       access_ok;
   logic       load_md_mem;

   map_if map_bus ();

   // Hold the accepted micro-operation for the whole cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dest_q  <= DEST_NONE;
         src_q   <= SRC_NONE;
         memop_q <= MEMOP_NONE;
      end else if (uop_valid && uop_ready) begin
         dest_q  <= uop_dest;
         src_q   <= uop_src;
         memop_q <= uop_memop;
      end
   end

   always_ff @(posedge clk) begin
      if (uop_valid && uop_ready) begin
         data_q <= uop_data;
      end
   end

   cycle_seq #(
      .MEM_TIMEOUT_CYCLES(MEM_TIMEOUT_CYCLES)
   ) seq0 (
      .clk         (clk),
      .rst_n       (rst_n),
      .uop_valid   (uop_valid),
      .uop_ready   (uop_ready),
      .mem_start   (mem_start),
      .mem_we_req  (mem_we_req),
      .access_ok   (access_ok),
      .mem_valid   (mem_valid),
      .mem_ready   (mem_ready),
      .mem_rvalid  (mem_rvalid),
      .state       (state),
      .load_md_mem (load_md_mem),
      .res_valid   (res_valid),
      .res_fault   (res_fault)
   );

   vma_md_ctl ctl0 (
      .state      (state),
      .uop_dest   (dest_q),
      .uop_src    (src_q),
      .uop_memop  (memop_q),
      .vma        (vma),
      .map        (map_bus.ctl),
      .vma_load   (vma_load),
      .md_load    (md_load),
      .mem_start  (mem_start),
      .mem_we_req (mem_we_req)
   );

   vma_md_regs regs0 (
      .clk         (clk),
      .rst_n       (rst_n),
      .vma_load    (vma_load),
      .md_load     (md_load),
      .load_md_mem (load_md_mem),
      .uop_data    (data_q),
      .mem_rdata   (mem_rdata),
      .vma         (vma),
      .md          (md)
   );

   vmem_map map0 (
      .clk        (clk),
      .vma        (vma),
      .map        (map_bus.map),
      .mem_we_req (mem_we_req),
      .phys       (phys),
      .access_ok  (access_ok)
   );

   // Map writes take their data from MD
   assign map_bus.wdata = md;

   assign mem_addr  = phys;
   assign mem_wdata = md;
   assign mem_we    = mem_we_req;

   always_comb begin
      case (src_q)
         SRC_MD:  res_data = md;
         SRC_MAP: res_data = word_t'(map_bus.l2_q);
         default: res_data = '0;
      endcase
   end

endmodule

// ==== src/vma_md_ctl.sv ====
// VMA and MD control decode with map strobes and memory start
module vma_md_ctl (
   input  cadr_mem_pkg::cyc_state_t state,
   input  cadr_mem_pkg::dest_t      uop_dest,
   input  cadr_mem_pkg::src_t       uop_src,
   input  cadr_mem_pkg::memop_t     uop_memop,
   input  cadr_mem_pkg::vaddr_t     vma,
   map_if.ctl                       map,
   output logic                     vma_load,
   output logic                     md_load,
   output logic                     mem_start,
   output logic                     mem_we_req
);
   import cadr_mem_pkg::*;

   logic state_decode;
   logic state_read;
   logic state_write;
   logic state_mmu;
   logic destmem;
   logic destvma;
   logic destmdr;
   logic srcmap;
   logic wmap;
   logic memwr;
   logic memrd;
   logic memprepare;

   assign state_decode = (state == ST_DECODE);
   assign state_read   = (state == ST_READ);
   assign state_write  = (state == ST_WRITE);
   assign state_mmu    = (state == ST_MMU);

   // Either register destination counts as a memory destination
   assign destvma = (uop_dest == DEST_VMA);
   assign destmdr = (uop_dest == DEST_MDR);
   assign destmem = destvma || destmdr;
   assign srcmap  = (uop_src == SRC_MAP);

   // Memory operation enables
   always_comb begin
      {wmap, memwr, memrd} = 3'b000;
      if (destmem) begin
         case (uop_memop)
            MEMOP_READ:  memrd = 1'b1;
            MEMOP_WRITE: memwr = 1'b1;
            MEMOP_MAPWR: wmap  = 1'b1;
            default:     {wmap, memwr, memrd} = 3'b000;
         endcase
      end
   end

   assign memprepare = memrd || memwr;
   assign mem_start  = memprepare;
   assign mem_we_req = memwr;

   ////////////////////
   // Map strobes
   ////////////////////

   // Early read for a map source, normal read ahead of translation
   assign map.vm0rp = (state_decode && srcmap) || (state_write && (wmap || memprepare));
   assign map.vm1rp = (state_read && srcmap) || (state_mmu && mem_start);

   assign map.vm0wp = wmap && vma[MAPWR_L1_BIT] && state_write;
   assign map.vm1wp = wmap && vma[MAPWR_L2_BIT] && state_mmu;

   // Register loads at the end of decode
   assign vma_load = state_decode && destvma;
   // Memory only loads MD in the read wait, never during decode
   assign md_load  = state_decode && destmdr;

endmodule

// ==== src/vma_md_regs.sv ====
// VMA and MD registers with load source selection
module vma_md_regs (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 vma_load,
   input  logic                 md_load,
   input  logic                 load_md_mem,
   input  cadr_mem_pkg::word_t  uop_data,
   input  cadr_mem_pkg::word_t  mem_rdata,
   output cadr_mem_pkg::vaddr_t vma,
   output cadr_mem_pkg::word_t  md
);
   import cadr_mem_pkg::*;

   word_t md_next;
   logic  md_en;

   // Memory read data wins over micro-operation data
   assign md_next = load_md_mem ? mem_rdata : uop_data;
   assign md_en   = load_md_mem || md_load;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vma <= '0;
      end else if (vma_load) begin
         vma <= vaddr_t'(uop_data);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         md <= '0;
      end else if (md_en) begin
         md <= md_next;
      end
   end

endmodule

// ==== src/vmem_map.sv ====
// Level-1 and level-2 map memories, address translation and access check
module vmem_map (
   input  logic                 clk,
   input  cadr_mem_pkg::vaddr_t vma,
   map_if.map                   map,
   input  logic                 mem_we_req,
   output cadr_mem_pkg::paddr_t phys,
   output logic                 access_ok
);
   import cadr_mem_pkg::*;

   l1_entry_t l1_mem [2**L1_INDEX_W];
   l2_entry_t l2_mem [2**L2_INDEX_W];

   l1_index_t l1_idx;
   l2_index_t l2_idx;
   l2_entry_t l2_hit;

   assign l1_idx = vma[L1_INDEX_LO +: L1_INDEX_W];
   // Level-2 index uses the registered level-1 entry
   assign l2_idx = {map.l1_q, vma[L2_OFFSET_LO +: (L1_INDEX_LO - L2_OFFSET_LO)]};

   ////////////////////
   // Level 1
   ////////////////////

   // A write and a read in the same phase return the old entry
   always_ff @(posedge clk) begin
      if (map.vm0wp) begin
         l1_mem[l1_idx] <= map.wdata[$bits(l1_entry_t)-1:0];
      end
      if (map.vm0rp) begin
         map.l1_q <= l1_mem[l1_idx];
      end
   end

   ////////////////////
   // Level 2
   ////////////////////

   always_ff @(posedge clk) begin
      if (map.vm1wp) begin
         l2_mem[l2_idx] <= map.wdata[$bits(l2_entry_t)-1:0];
      end
      if (map.vm1rp) begin
         map.l2_q <= l2_mem[l2_idx];
      end
   end

   // Direct lookup so the request can leave in the mmu phase
   assign l2_hit = l2_mem[l2_idx];

   // Page from the map, offset straight from VMA
   assign phys = {l2_hit[PAGE_W-1:0], vma[L2_OFFSET_LO-1:0]};

   assign access_ok = mem_we_req ? l2_hit[L2_WR_BIT] : l2_hit[L2_RD_BIT];

endmodule

// ==== verification/mem_ctl_tb.sv ====
// Testbench with clock, reset, LFSR stimulus, memory responder, reference model and checks
module mem_ctl_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import cadr_mem_pkg::*;

   localparam int WAIT_LIMIT = 200;

   logic   clk;
   logic   rst_n;
   logic   uop_valid;
   logic   uop_ready;
   dest_t  uop_dest;
   src_t   uop_src;
   memop_t uop_memop;
   word_t  uop_data;
   logic   res_valid;
   word_t  res_data;
   logic   res_fault;
   logic   mem_valid;
   logic   mem_ready;
   logic   mem_we;
   paddr_t mem_addr;
   word_t  mem_wdata;
   logic   mem_rvalid;
   word_t  mem_rdata;

   // Reference state: maps, VMA, MD and memory
   l1_entry_t l1_m [l1_index_t];
   l2_entry_t l2_m [l2_index_t];
   word_t     mem_m [paddr_t];
   vaddr_t    m_vma;
   word_t     m_md;

   word_t       mem_store [paddr_t];
   logic [32:0] exp_q [$];
   logic [54:0] req_q [$];
   logic [31:0] lfsr;
   logic        timed_out;
   int          errors;
   int          errors_before;
   int          checks;

   mem_ctl_top #(
      .MEM_TIMEOUT_CYCLES(64)
   ) dut0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .uop_valid  (uop_valid),
      .uop_ready  (uop_ready),
      .uop_dest   (uop_dest),
      .uop_src    (uop_src),
      .uop_memop  (uop_memop),
      .uop_data   (uop_data),
      .res_valid  (res_valid),
      .res_data   (res_data),
      .res_fault  (res_fault),
      .mem_valid  (mem_valid),
      .mem_ready  (mem_ready),
      .mem_we     (mem_we),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_rvalid (mem_rvalid),
      .mem_rdata  (mem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////
   // Helpers
   ////////////////////

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // One LFSR step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      int          i;
      r = '0;
      for (i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // Only four level-1 slots are mapped, bit 26 stays clear
   function automatic vaddr_t rand_vma();
      logic [31:0] hi;
      logic [31:0] b25;
      logic [31:0] idx;
      logic [31:0] off;
      logic [31:0] lo;
      hi  = take_bits(5);
      b25 = take_bits(1);
      idx = take_bits(2);
      off = take_bits(5);
      lo  = take_bits(8);
      return {hi[4:0], 1'b0, b25[0], 10'b0, idx[1:0], off[4:0], lo[7:0]};
   endfunction

   function automatic word_t fill_word(input paddr_t a);
      return {~a[9:0], a};
   endfunction

   // Expected {fault, data} for one micro-operation
   function automatic logic [32:0] model_uop(input dest_t d, input src_t s, input memop_t m,
                                             input word_t data);
      l1_entry_t l1e;
      l2_entry_t early;
      l2_entry_t l2e;
      paddr_t    pa;
      logic      wmap;
      logic      start;
      logic      ok;
      word_t     res;
      early = '0;
      l2e   = '0;
      l1e   = '0;
      ok    = 1'b1;
      // Map source reads level 1 in decode, before VMA loads
      if (s == SRC_MAP) begin
         l1e = l1_m[m_vma[23:13]];
      end
      if (d == DEST_VMA) begin
         m_vma = data;
      end
      if (d == DEST_MDR) begin
         m_md = data;
      end
      if (s == SRC_MAP) begin
         early = l2_m[{l1e, m_vma[12:8]}];
      end
      wmap  = (d != DEST_NONE) && (m == MEMOP_MAPWR);
      start = (d != DEST_NONE) && (m == MEMOP_READ || m == MEMOP_WRITE);
      if (wmap || start) begin
         l1e = l1_m[m_vma[23:13]];
         if (wmap && m_vma[26]) begin
            l1_m[m_vma[23:13]] = m_md[4:0];
         end
         // Level-2 write goes through the entry read before any level-1 write
         if (wmap && m_vma[25]) begin
            l2_m[{l1e, m_vma[12:8]}] = m_md[23:0];
         end
      end
      if (start) begin
         l2e = l2_m[{l1e, m_vma[12:8]}];
         pa  = {l2e[13:0], m_vma[7:0]};
         ok  = (m == MEMOP_WRITE) ? l2e[22] : l2e[23];
         if (ok && m == MEMOP_WRITE) begin
            mem_m[pa] = m_md;
            req_q.push_back({1'b1, pa, m_md});
         end else if (ok) begin
            m_md = mem_m.exists(pa) ? mem_m[pa] : fill_word(pa);
            req_q.push_back({1'b0, pa, 32'h0});
         end
      end
      case (s)
         SRC_MD:  res = m_md;
         SRC_MAP: res = start ? 32'(l2e) : 32'(early);
         default: res = '0;
      endcase
      return {!ok, res};
   endfunction

   task automatic flag_timeout(input string what);
      $display("Timed out waiting for %s at %0t", what, $time);
      timed_out = 1'b1;
      errors++;
   endtask

   task automatic report_test(input string name);
      if (errors == errors_before) begin
         $display("Test %s: ok", name);
      end else begin
         $display("Test %s: %0d errors", name, errors - errors_before);
      end
      errors_before = errors;
   endtask

   // Sends one micro-operation and waits until its result has been compared
   task automatic send_uop(input dest_t d, input src_t s, input memop_t m, input word_t data,
                           output int latency);
      logic [32:0] exp;
      int          n;
      latency = 0;
      if (timed_out) begin
         return;
      end
      exp = model_uop(d, s, m, data);
      n   = 0;
      @(negedge clk);
      while (!uop_ready && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!uop_ready) begin
         flag_timeout("uop_ready");
         return;
      end
      exp_q.push_back(exp);
      uop_valid = 1'b1;
      uop_dest  = d;
      uop_src   = s;
      uop_memop = m;
      uop_data  = data;
      @(posedge clk);
      @(negedge clk);
      uop_valid = 1'b0;
      if (uop_ready) begin
         $display("CHECK FAILED at %0t: micro-operation was not accepted", $time);
         errors++;
      end
      while (exp_q.size() != 0 && latency < WAIT_LIMIT) begin
         @(posedge clk);
         latency++;
      end
      if (exp_q.size() != 0) begin
         flag_timeout("res_valid");
      end
   endtask

   task automatic issue(input dest_t d, input src_t s, input memop_t m, input word_t data);
      int lat;
      send_uop(d, s, m, data, lat);
   endtask

   // MD first, then a VMA load that carries the map write
   task automatic map_write(input vaddr_t v, input word_t entry);
      issue(DEST_MDR, SRC_NONE, MEMOP_NONE, entry);
      issue(DEST_VMA, SRC_NONE, MEMOP_MAPWR, v);
   endtask

   ////////////////////
   // Result compare
   ////////////////////

   initial begin : compare_results
      logic [32:0] exp;
      forever begin
         @(negedge clk);
         if (rst_n && res_valid) begin
            if (exp_q.size() == 0) begin
               $display("Result arrived with no micro-operation pending at %0t", $time);
               errors++;
            end else begin
               exp = exp_q.pop_front();
               checks++;
               if (res_fault !== exp[32] || res_data !== exp[31:0]) begin
                  $display("CHECK FAILED at %0t: result fault %b data %h, expected %b %h",
                           $time, res_fault, res_data, exp[32], exp[31:0]);
                  errors++;
               end
            end
         end
      end
   end

   ////////////////////
   // Memory responder
   ////////////////////

   initial begin : memory_responder
      logic [54:0] req;
      logic [31:0] delay;
      paddr_t      addr_q;
      word_t       wdata_q;
      logic        we_q;
      int          i;
      forever begin
         @(negedge clk);
         mem_ready  = 1'b0;
         mem_rvalid = 1'b0;
         if (rst_n && mem_valid) begin
            addr_q  = mem_addr;
            wdata_q = mem_wdata;
            we_q    = mem_we;
            if (req_q.size() == 0) begin
               $display("Memory request issued where none belongs at %0t", $time);
               errors++;
            end else begin
               req = req_q.pop_front();
               if (we_q !== req[54] || addr_q !== req[53:32] ||
                   (req[54] && wdata_q !== req[31:0])) begin
                  $display("CHECK FAILED at %0t: request we %b addr %h data %h, expected %b %h %h",
                           $time, we_q, addr_q, wdata_q, req[54], req[53:32], req[31:0]);
                  errors++;
               end
            end
            // Random stall, the request must hold still
            delay = take_bits(3);
            for (i = 0; i < delay; i++) begin
               @(negedge clk);
               if (!mem_valid || mem_addr !== addr_q || mem_wdata !== wdata_q || uop_ready) begin
                  $display("CHECK FAILED at %0t: request changed during a stall", $time);
                  errors++;
               end
            end
            mem_ready = 1'b1;
            if (we_q) begin
               mem_store[addr_q] = wdata_q;
            end else begin
               @(negedge clk);
               mem_ready = 1'b0;
               delay     = take_bits(2);
               for (i = 0; i < delay; i++) begin
                  @(negedge clk);
               end
               mem_rdata  = mem_store.exists(addr_q) ? mem_store[addr_q] : fill_word(addr_q);
               mem_rvalid = 1'b1;
            end
         end
      end
   end

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin : main
      int          lat;
      int          i;
      int          j;
      vaddr_t      v3;
      logic [31:0] r;
      dest_t       d;
      src_t        s;
      memop_t      m;
      word_t       w;
      lfsr          = 32'heba6;
      timed_out     = 1'b0;
      errors        = 0;
      errors_before = 0;
      checks        = 0;
      m_vma         = '0;
      m_md          = '0;
      rst_n         = 1'b0;
      uop_valid     = 1'b0;
      uop_dest      = DEST_NONE;
      uop_src       = SRC_NONE;
      uop_memop     = MEMOP_NONE;
      uop_data      = '0;
      mem_ready     = 1'b0;
      mem_rvalid    = 1'b0;
      mem_rdata     = '0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      // Reset state and fixed latency
      if (uop_ready !== 1'b1 || mem_valid !== 1'b0 || res_valid !== 1'b0) begin
         $display("CHECK FAILED at %0t: reset outputs ready %b mem_valid %b res_valid %b",
                  $time, uop_ready, mem_valid, res_valid);
         errors++;
      end
      send_uop(DEST_MDR, SRC_MD, MEMOP_NONE, take_bits(32), lat);
      if (lat != 5) begin
         $display("CHECK FAILED at %0t: latency %0d, expected 5", $time, lat);
         errors++;
      end
      issue(DEST_NONE, SRC_NONE, MEMOP_NONE, take_bits(32));
      report_test("reset and latency");

      // Four level-1 slots, each pointing at a fully written level-2 block
      for (i = 0; i < 4; i++) begin
         map_write(32'h0400_0000 | (i << 13), word_t'({i[1:0], 3'b101}));
      end
      for (i = 0; i < 4; i++) begin
         for (j = 0; j < 32; j++) begin
            map_write(32'h0200_0000 | (i << 13) | (j << 8), take_bits(24));
         end
      end
      for (i = 0; i < 8; i++) begin
         issue(DEST_VMA, SRC_NONE, MEMOP_NONE, rand_vma());
         issue(DEST_NONE, SRC_MAP, MEMOP_NONE, '0);
      end
      report_test("map write and read-back");

      // Page with read and write allowed
      r = take_bits(14);
      map_write(32'h0200_0000 | (2 << 13) | (5 << 8), {8'h0, 2'b11, 8'h0, r[13:0]});
      v3 = (2 << 13) | (5 << 8) | 8'h3c;
      issue(DEST_VMA, SRC_NONE, MEMOP_NONE, v3);
      issue(DEST_MDR, SRC_MD, MEMOP_WRITE, take_bits(32));
      issue(DEST_MDR, SRC_NONE, MEMOP_NONE, '0);
      issue(DEST_VMA, SRC_MD, MEMOP_READ, v3);
      report_test("translated write and read");

      // Read-only page, then write-only page
      r = take_bits(14);
      map_write(32'h0200_0000 | (1 << 13) | (3 << 8), {8'h0, 2'b10, 8'h0, r[13:0]});
      issue(DEST_VMA, SRC_NONE, MEMOP_NONE, (1 << 13) | (3 << 8) | 8'h44);
      issue(DEST_MDR, SRC_MD, MEMOP_WRITE, take_bits(32));
      map_write(32'h0200_0000 | (1 << 13) | (3 << 8), {8'h0, 2'b01, 8'h0, r[13:0]});
      issue(DEST_VMA, SRC_MAP, MEMOP_READ, (1 << 13) | (3 << 8) | 8'h45);
      report_test("protection fault");

      // Stalls come from the responder on every request
      for (i = 0; i < 12; i++) begin
         r = take_bits(8);
         issue(DEST_VMA, SRC_NONE, MEMOP_NONE, (v3 & 32'hffff_ff00) | r[7:0]);
         issue(DEST_MDR, SRC_MD, MEMOP_WRITE, take_bits(32));
         // MD cleared so the read result has to come from memory
         issue(DEST_MDR, SRC_NONE, MEMOP_NONE, '0);
         issue(DEST_VMA, SRC_MD, MEMOP_READ, (v3 & 32'hffff_ff00) | r[7:0]);
      end
      report_test("back-pressure");

      issue(DEST_VMA, SRC_NONE, MEMOP_NONE, rand_vma());
      for (i = 0; i < 200; i++) begin
         r = take_bits(2);
         d = (r[1:0] == 2'b11) ? DEST_MDR : dest_t'(r[1:0]);
         r = take_bits(2);
         s = (r[1:0] == 2'b11) ? SRC_MAP : src_t'(r[1:0]);
         r = take_bits(2);
         m = memop_t'(r[1:0]);
         w = (d == DEST_VMA) ? rand_vma() : take_bits(32);
         issue(d, s, m, w);
      end
      report_test("random mix");

      if (req_q.size() != 0) begin
         $display("%0d expected memory requests never appeared", req_q.size());
         errors++;
      end
      $display("Results compared %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule
